// File: Makefile
# Verilator flow for the baseband link core

VERILATOR ?= verilator
TOP       ?= bt_tb
FILELIST  ?= bt_baseband.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bt_baseband.f
hdl/bt_pkg.sv
hdl/bt_regs.sv
hdl/bt_link_ctrl.sv
hdl/bt_tx_serializer.sv
hdl/bt_whitening.sv
hdl/bt_sync_correlator.sv
hdl/bt_rx_deserializer.sv
hdl/bt_top.sv
tb/bt_properties.sv
tb/bt_tb.sv

// File: hdl/bt_link_ctrl.sv
`timescale 1ns/1ps
module bt_link_ctrl #(
  parameter int BIT_DIV = 6
) (
  input  logic             m_clk_6M,
  input  logic             reset,
  input  logic             tx_start,
  input  logic             rx_arm,
  input  logic             whiten_en,
  input  bt_pkg::chan_t    base_chan,
  input  bt_pkg::wb_data_t rx_window,
  input  logic             sync_hit,
  output logic             bit_tick,
  output logic             tx_load,
  output logic             tx_shift,
  output logic             tx_phase_payload,
  output logic             tx_seed_load,
  output logic             tx_lfsr_step,
  output logic             rx_search_en,
  output logic             rx_capture,
  output logic             rx_seed_load,
  output logic             rx_lfsr_step,
  output logic             rx_done,
  output logic             rx_timeout_set,
  output logic             tx_busy,
  output logic             rx_busy,
  output bt_pkg::chan_t    fk
);

  localparam int DIV_W = (BIT_DIV > 1) ? $clog2(BIT_DIV) : 1;

  logic [DIV_W-1:0]  div_cnt;
  bt_pkg::tx_state_t tx_state;
  bt_pkg::rx_state_t rx_state;
  logic [6:0]        tx_cnt;    // bits sent, 96 is the closing tick
  logic [5:0]        rx_cnt;    // payload bits captured
  bt_pkg::wb_data_t  win_cnt;
  bt_pkg::chan_t     hop_cnt;
  bt_pkg::chan_t     base_mod;
  logic [7:0]        fk_sum;

  assign bit_tick = (div_cnt == DIV_W'(BIT_DIV - 1));

  always_ff @(posedge m_clk_6M) begin
    if (reset) div_cnt <= '0;
    else       div_cnt <= bit_tick ? '0 : div_cnt + 1'b1;
  end

  assign tx_busy          = (tx_state != bt_pkg::tx_idle);
  assign tx_load          = tx_start && !tx_busy;
  assign tx_seed_load     = tx_load;
  assign tx_shift         = bit_tick && tx_busy;
  assign tx_phase_payload = (tx_state == bt_pkg::tx_payload) && (tx_cnt != 7'd96) && whiten_en;
  assign tx_lfsr_step     = tx_shift && tx_phase_payload;

  always_ff @(posedge m_clk_6M) begin
    if (reset) begin
      tx_state <= bt_pkg::tx_idle;
      tx_cnt   <= '0;
      hop_cnt  <= '0;
    end else begin
      case (tx_state)
        bt_pkg::tx_idle: if (tx_load) begin
          tx_state <= bt_pkg::tx_sync;
          tx_cnt   <= '0;
        end
        bt_pkg::tx_sync: if (tx_shift) begin
          tx_cnt <= tx_cnt + 7'd1;
          if (tx_cnt == 7'd63) tx_state <= bt_pkg::tx_payload;
        end
        default: if (tx_shift) begin
          if (tx_cnt == 7'd96) begin  // last payload bit has been held
            tx_state <= bt_pkg::tx_idle;
            hop_cnt  <= (hop_cnt == 7'(bt_pkg::NUM_CHANNELS - 1)) ? '0 : hop_cnt + 7'd1;
          end else begin
            tx_cnt <= tx_cnt + 7'd1;
          end
        end
      endcase
    end
  end

  assign rx_busy        = (rx_state != bt_pkg::rx_idle);
  assign rx_search_en   = (rx_state == bt_pkg::rx_search);
  assign rx_seed_load   = rx_arm && !rx_busy;
  assign rx_capture     = bit_tick && (rx_state == bt_pkg::rx_payload) && (rx_cnt != 6'd32);
  assign rx_lfsr_step   = rx_capture && whiten_en;
  assign rx_done        = (rx_state == bt_pkg::rx_payload) && (rx_cnt == 6'd32);
  assign rx_timeout_set = rx_search_en && bit_tick && !sync_hit && (win_cnt + 32'd1 >= rx_window);

  always_ff @(posedge m_clk_6M) begin
    if (reset) begin
      rx_state <= bt_pkg::rx_idle;
      rx_cnt   <= '0;
      win_cnt  <= '0;
    end else begin
      case (rx_state)
        bt_pkg::rx_idle: if (rx_seed_load) begin
          rx_state <= bt_pkg::rx_search;
          win_cnt  <= '0;
        end
        bt_pkg::rx_search: begin
          if (sync_hit) begin
            rx_state <= bt_pkg::rx_payload;
            rx_cnt   <= '0;
          end else if (rx_timeout_set) begin
            rx_state <= bt_pkg::rx_idle;
          end else if (bit_tick) begin
            win_cnt <= win_cnt + 32'd1;
          end
        end
        default: begin
          if (rx_done) rx_state <= bt_pkg::rx_idle;
          else if (rx_capture) rx_cnt <= rx_cnt + 6'd1;
        end
      endcase
    end
  end

  // fk = (base + packets sent) mod 79
  assign base_mod = (base_chan >= 7'(bt_pkg::NUM_CHANNELS)) ?
                    base_chan - 7'(bt_pkg::NUM_CHANNELS) : base_chan;
  assign fk_sum   = {1'b0, base_mod} + {1'b0, hop_cnt};
  assign fk       = (fk_sum >= 8'(bt_pkg::NUM_CHANNELS)) ?
                    7'(fk_sum - 8'(bt_pkg::NUM_CHANNELS)) : fk_sum[6:0];

endmodule

// File: hdl/bt_pkg.sv
package bt_pkg;

  typedef logic [63:0] syncword_t;  // access code sync word
  typedef logic [31:0] payload_t;   // packet payload
  typedef logic [6:0]  chan_t;      // hop channel 0..78
  typedef logic [6:0]  lfsr_t;      // whitening state and seed
  typedef logic [6:0]  corr_t;      // agreement count 0..64, also threshold
  typedef logic [2:0]  wb_addr_t;   // wishbone word address
  typedef logic [31:0] wb_data_t;   // wishbone data

  typedef enum logic [1:0] {
    tx_idle,
    tx_sync,
    tx_payload
  } tx_state_t;

  typedef enum logic [1:0] {
    rx_idle,
    rx_search,
    rx_payload
  } rx_state_t;

  // register map, word addresses
  localparam wb_addr_t REG_CTRL      = 3'd0;
  localparam wb_addr_t REG_STATUS    = 3'd1;
  localparam wb_addr_t REG_SYNC_LO   = 3'd2;
  localparam wb_addr_t REG_SYNC_HI   = 3'd3;
  localparam wb_addr_t REG_CONFIG    = 3'd4;  // threshold, seed, base channel
  localparam wb_addr_t REG_TX_DATA   = 3'd5;
  localparam wb_addr_t REG_RX_DATA   = 3'd6;
  localparam wb_addr_t REG_RX_WINDOW = 3'd7;

  localparam int NUM_CHANNELS = 79;  // 2.4 GHz hop set

endpackage

// File: hdl/bt_regs.sv
`timescale 1ns/1ps
module bt_regs (
  input  logic              m_clk_6M,
  input  logic              reset,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  bt_pkg::wb_addr_t  wb_adr,
  input  bt_pkg::wb_data_t  wb_wdata,
  output bt_pkg::wb_data_t  wb_rdata,
  output logic              wb_ack,
  input  logic              tx_busy,
  input  logic              rx_busy,
  input  bt_pkg::chan_t     fk,
  input  logic              rx_done,
  input  logic              rx_timeout_set,
  input  bt_pkg::payload_t  rx_word,
  output bt_pkg::syncword_t sync_word,
  output bt_pkg::payload_t  tx_data,
  output bt_pkg::corr_t     threshold,
  output bt_pkg::lfsr_t     whiten_seed,
  output logic              whiten_en,
  output bt_pkg::chan_t     base_chan,
  output bt_pkg::wb_data_t  rx_window,
  output logic              tx_start,
  output logic              rx_arm,
  output logic              irq
);

  logic             wr_en;
  logic             rx_valid;
  logic             rx_timeout;
  bt_pkg::payload_t rx_data;

  // write lands on the ack edge
  assign wr_en = wb_ack && wb_cyc && wb_stb && wb_we;

  assign tx_start = wr_en && (wb_adr == bt_pkg::REG_CTRL) && wb_wdata[0];
  assign rx_arm   = wr_en && (wb_adr == bt_pkg::REG_CTRL) && wb_wdata[1];

  always_ff @(posedge m_clk_6M) begin
    if (reset) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= wb_cyc && wb_stb && !wb_ack;  // single cycle ack
    end
  end

  always_ff @(posedge m_clk_6M) begin
    if (reset) begin
      whiten_en   <= 1'b0;
      threshold   <= '0;
      whiten_seed <= '0;
      base_chan   <= '0;
      rx_window   <= '0;
    end else if (wr_en) begin
      case (wb_adr)
        bt_pkg::REG_CTRL:      whiten_en <= wb_wdata[2];
        bt_pkg::REG_CONFIG: begin
          threshold   <= wb_wdata[6:0];
          whiten_seed <= wb_wdata[14:8];
          base_chan   <= wb_wdata[22:16];
        end
        bt_pkg::REG_RX_WINDOW: rx_window <= wb_wdata;
        default: ;
      endcase
    end
  end

  // data words
  always_ff @(posedge m_clk_6M) begin
    if (wr_en && wb_adr == bt_pkg::REG_SYNC_LO) sync_word[31:0] <= wb_wdata;
    if (wr_en && wb_adr == bt_pkg::REG_SYNC_HI) sync_word[63:32] <= wb_wdata;
    if (wr_en && wb_adr == bt_pkg::REG_TX_DATA) tx_data <= wb_wdata;
    if (rx_done) rx_data <= rx_word;
  end

  // sticky receive flags, cleared by arming
  always_ff @(posedge m_clk_6M) begin
    if (reset) begin
      rx_valid   <= 1'b0;
      rx_timeout <= 1'b0;
    end else begin
      if (rx_arm) begin
        rx_valid   <= 1'b0;
        rx_timeout <= 1'b0;
      end
      if (rx_done) rx_valid <= 1'b1;
      if (rx_timeout_set) rx_timeout <= 1'b1;
    end
  end

  assign irq = rx_valid || rx_timeout;

  always_comb begin
    case (wb_adr)
      bt_pkg::REG_CTRL:      wb_rdata = {29'd0, whiten_en, 2'b00};
      bt_pkg::REG_STATUS:    wb_rdata = {17'd0, fk, 4'd0, rx_timeout, rx_valid,
                                         rx_busy, tx_busy};
      bt_pkg::REG_SYNC_LO:   wb_rdata = sync_word[31:0];
      bt_pkg::REG_SYNC_HI:   wb_rdata = sync_word[63:32];
      bt_pkg::REG_CONFIG:    wb_rdata = {9'd0, base_chan, 1'b0, whiten_seed, 1'b0,
                                         threshold};
      bt_pkg::REG_TX_DATA:   wb_rdata = tx_data;
      bt_pkg::REG_RX_DATA:   wb_rdata = rx_data;
      default:               wb_rdata = rx_window;
    endcase
  end

endmodule

// File: hdl/bt_rx_deserializer.sv
`timescale 1ns/1ps
module bt_rx_deserializer (
  input  logic             m_clk_6M,
  input  logic             reset,
  input  logic             capture,
  input  logic             rxbit,
  input  logic             whiten_bit,
  input  logic             dewhiten_en,
  output bt_pkg::payload_t rx_word
);

  logic data_bit;

  // rx lfsr keeps its old state when whitening is off
  assign data_bit = rxbit ^ (dewhiten_en & whiten_bit);

  always_ff @(posedge m_clk_6M) begin
    if (reset) begin
      rx_word <= '0;
    end else if (capture) begin
      rx_word <= {data_bit, rx_word[31:1]};  // first bit ends in bit 0
    end
  end

endmodule

// File: hdl/bt_sync_correlator.sv
`timescale 1ns/1ps
module bt_sync_correlator (
  input  logic              m_clk_6M,
  input  logic              reset,
  input  logic              search_en,
  input  logic              bit_tick,
  input  logic              rxbit,
  input  bt_pkg::syncword_t sync_word,
  input  bt_pkg::corr_t     threshold,
  output logic              sync_hit
);

  bt_pkg::syncword_t hist;   // bit 0 is the oldest sample
  logic [6:0]        fill;   // samples taken, saturates at 64
  bt_pkg::corr_t     agree;

  always_ff @(posedge m_clk_6M) begin
    if (reset || !search_en) begin
      hist <= '0;
      fill <= '0;
    end else if (bit_tick) begin
      hist <= {rxbit, hist[63:1]};
      if (fill != 7'd64) fill <= fill + 7'd1;
    end
  end

  always_comb begin
    agree = '0;
    for (int i = 0; i < 64; i++) begin
      agree = agree + {6'd0, hist[i] ~^ sync_word[i]};
    end
  end

  // only a full window of samples may match
  assign sync_hit = search_en && (fill == 7'd64) && (agree >= threshold);

endmodule

// File: hdl/bt_top.sv
`timescale 1ns/1ps
module bt_top #(
  parameter int BIT_DIV = 6  // 1 Mbit/s at 6 MHz
) (
  input  logic             m_clk_6M,
  input  logic             reset,
  input  logic             wb_cyc,
  input  logic             wb_stb,
  input  logic             wb_we,
  input  bt_pkg::wb_addr_t wb_adr,
  input  bt_pkg::wb_data_t wb_wdata,
  output bt_pkg::wb_data_t wb_rdata,
  output logic             wb_ack,
  input  logic             rxbit,
  output logic             txbit,
  output bt_pkg::chan_t    fk,
  output logic             irq
);

  bt_pkg::syncword_t sync_word;
  bt_pkg::payload_t  tx_data;
  bt_pkg::payload_t  rx_word;
  bt_pkg::corr_t     threshold;
  bt_pkg::lfsr_t     whiten_seed;
  bt_pkg::chan_t     base_chan;
  bt_pkg::wb_data_t  rx_window;
  logic whiten_en, tx_start, rx_arm, tx_busy, rx_busy;
  logic bit_tick, tx_load, tx_shift, tx_phase_payload, tx_seed_load, tx_lfsr_step;
  logic rx_search_en, rx_capture, rx_seed_load, rx_lfsr_step, rx_done, rx_timeout_set;
  logic sync_hit, tx_whiten_bit, rx_whiten_bit;

  bt_regs u_regs (
    .m_clk_6M, .reset,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_wdata, .wb_rdata, .wb_ack,
    .tx_busy, .rx_busy, .fk, .rx_done, .rx_timeout_set, .rx_word,
    .sync_word, .tx_data, .threshold, .whiten_seed, .whiten_en,
    .base_chan, .rx_window, .tx_start, .rx_arm, .irq
  );

  bt_link_ctrl #(.BIT_DIV(BIT_DIV)) u_link_ctrl (
    .m_clk_6M, .reset,
    .tx_start, .rx_arm, .whiten_en, .base_chan, .rx_window, .sync_hit,
    .bit_tick, .tx_load, .tx_shift, .tx_phase_payload, .tx_seed_load, .tx_lfsr_step,
    .rx_search_en, .rx_capture, .rx_seed_load, .rx_lfsr_step, .rx_done,
    .rx_timeout_set, .tx_busy, .rx_busy, .fk
  );

  bt_tx_serializer u_tx_serializer (
    .m_clk_6M, .reset,
    .tx_load, .tx_shift, .tx_phase_payload, .sync_word, .tx_data,
    .whiten_bit (tx_whiten_bit),
    .txbit
  );

  bt_whitening tx_whitening (
    .m_clk_6M, .reset,
    .seed_load  (tx_seed_load),
    .step       (tx_lfsr_step),
    .seed       (whiten_seed),
    .whiten_bit (tx_whiten_bit)
  );

  bt_whitening rx_whitening (
    .m_clk_6M, .reset,
    .seed_load  (rx_seed_load),
    .step       (rx_lfsr_step),
    .seed       (whiten_seed),
    .whiten_bit (rx_whiten_bit)
  );

  bt_sync_correlator u_sync_correlator (
    .m_clk_6M, .reset,
    .search_en (rx_search_en),
    .bit_tick, .rxbit, .sync_word, .threshold, .sync_hit
  );

  bt_rx_deserializer u_rx_deserializer (
    .m_clk_6M, .reset,
    .capture     (rx_capture),
    .rxbit,
    .whiten_bit  (rx_whiten_bit),
    .dewhiten_en (whiten_en),
    .rx_word
  );

endmodule

// File: hdl/bt_tx_serializer.sv
`timescale 1ns/1ps
module bt_tx_serializer (
  input  logic              m_clk_6M,
  input  logic              reset,
  input  logic              tx_load,
  input  logic              tx_shift,
  input  logic              tx_phase_payload,
  input  bt_pkg::syncword_t sync_word,
  input  bt_pkg::payload_t  tx_data,
  input  logic              whiten_bit,
  output logic              txbit
);

  logic [95:0] shreg;  // payload above sync word, bit 0 goes first

  always_ff @(posedge m_clk_6M) begin
    if (tx_load) begin
      shreg <= {tx_data, sync_word};
    end else if (tx_shift) begin
      shreg <= {1'b0, shreg[95:1]};  // zero fill, line idles low after the packet
    end
  end

  always_ff @(posedge m_clk_6M) begin
    if (reset) begin
      txbit <= 1'b0;
    end else if (tx_load) begin
      txbit <= 1'b0;
    end else if (tx_shift) begin
      txbit <= shreg[0] ^ (tx_phase_payload & whiten_bit);
    end
  end

endmodule

// File: hdl/bt_whitening.sv
`timescale 1ns/1ps
module bt_whitening (
  input  logic          m_clk_6M,
  input  logic          reset,
  input  logic          seed_load,
  input  logic          step,
  input  bt_pkg::lfsr_t seed,
  output logic          whiten_bit
);

  bt_pkg::lfsr_t lfsr;

  // g(D) = D^7 + D^4 + 1, feedback from bit 6 into bits 0 and 4
  always_ff @(posedge m_clk_6M) begin
    if (reset) begin
      lfsr <= '0;
    end else if (seed_load) begin
      lfsr <= {1'b1, seed[5:0]};  // never all zero
    end else if (step) begin
      lfsr <= {lfsr[5:4], lfsr[3] ^ lfsr[6], lfsr[2:0], lfsr[6]};
    end
  end

  assign whiten_bit = lfsr[6];

endmodule

// File: tb/bt_properties.sv
`timescale 1ns/1ps
module bt_properties (
  input logic              m_clk_6M,
  input logic              reset,
  input logic              bit_tick,
  input logic              tx_busy,
  input bt_pkg::tx_state_t tx_state,
  input bt_pkg::rx_state_t rx_state,
  input logic              rx_done,
  input bt_pkg::chan_t     fk
);

  // divider pulse never lasts two clocks
  tick_one_clock: assert property (@(posedge m_clk_6M) disable iff (reset)
    bit_tick |=> !bit_tick)
    else $error("bit_tick held high for more than one clock");

  // a packet only ends out of the payload phase
  tx_busy_state: assert property (@(posedge m_clk_6M) disable iff (reset)
    $fell(tx_busy) |-> $past(tx_state) == bt_pkg::tx_payload)
    else $error("tx_busy fell outside the payload phase");

  fk_in_range: assert property (@(posedge m_clk_6M) disable iff (reset)
    fk < 7'(bt_pkg::NUM_CHANNELS))
    else $error("fk outside the hop set");

  // receive word completes one clock after a payload capture tick
  done_in_payload: assert property (@(posedge m_clk_6M) disable iff (reset)
    rx_done |-> $past(rx_state) == bt_pkg::rx_payload && $past(bit_tick))
    else $error("rx_done without a preceding payload capture");

endmodule

bind bt_link_ctrl bt_properties u_properties (
  .m_clk_6M (m_clk_6M),
  .reset    (reset),
  .bit_tick (bit_tick),
  .tx_busy  (tx_busy),
  .tx_state (tx_state),
  .rx_state (rx_state),
  .rx_done  (rx_done),
  .fk       (fk)
);

// File: tb/bt_tb.sv
`timescale 1ns/1ps
module bt_tb;

  localparam int TIMEOUT = 4000;  // clocks per wait

  logic              m_clk_6M, reset, wb_cyc, wb_stb, wb_we, wb_ack;
  logic              rxbit, txbit, irq;
  bt_pkg::wb_addr_t  wb_adr;
  bt_pkg::wb_data_t  wb_wdata, wb_rdata;
  bt_pkg::chan_t     fk, exp_fk, base;
  bt_pkg::syncword_t sync;
  logic [95:0]       err_mask;  // air bits to flip, index from tx start
  int                air_bits;
  int                pkt_count;

  bt_top #(.BIT_DIV(6)) UUT (.*);

  initial begin
    m_clk_6M = 1'b0;
    forever #4 m_clk_6M = ~m_clk_6M;
  end

  // channel between devices, one clock of air delay
  always @(posedge m_clk_6M) begin
    if (reset || !UUT.tx_busy) air_bits <= 0;
    else if (UUT.bit_tick) air_bits <= air_bits + 1;
    if (exp_fk == fk)
      rxbit <= txbit ^ ((air_bits > 0 && air_bits <= 96) ? err_mask[air_bits-1] : 1'b0);
    else
      rxbit <= 1'b0;  // other channel, nothing heard
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_payload(input string test, input bt_pkg::payload_t exp,
                               input bt_pkg::payload_t act);
    if (exp !== act)
      abort_run($sformatf("CHECK FAILED %s: expected %h actual %h", test, exp, act));
  endtask

  task automatic check_word(input string test, input bt_pkg::wb_data_t exp,
                            input bt_pkg::wb_data_t act);
    if (exp !== act)
      abort_run($sformatf("CHECK FAILED %s: expected %h actual %h", test, exp, act));
  endtask

  task automatic check_chan(input string test, input bt_pkg::chan_t exp,
                            input bt_pkg::chan_t act);
    if (exp !== act)
      abort_run($sformatf("CHECK FAILED %s: expected %0d actual %0d", test, exp, act));
  endtask

  task automatic check_status(input string test, input logic [3:0] exp, input logic [3:0] act);
    if (exp !== act)
      abort_run($sformatf("CHECK FAILED %s: expected %b actual %b", test, exp, act));
  endtask

  task automatic wb_write(input bt_pkg::wb_addr_t adr, input bt_pkg::wb_data_t data);
    int n;
    n = 0;
    @(posedge m_clk_6M);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= adr;
    wb_wdata <= data;
    do begin
      @(negedge m_clk_6M);
      n++;
      if (n > TIMEOUT) abort_run("no wishbone ack on a write");
    end while (!wb_ack);
    @(posedge m_clk_6M);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_read(input bt_pkg::wb_addr_t adr, output bt_pkg::wb_data_t data);
    int n;
    n = 0;
    @(posedge m_clk_6M);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    do begin
      @(negedge m_clk_6M);
      n++;
      if (n > TIMEOUT) abort_run("no wishbone ack on a read");
    end while (!wb_ack);
    data = wb_rdata;
    @(posedge m_clk_6M);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  task automatic wait_irq();
    int n;
    n = 0;
    while (!irq) begin
      @(negedge m_clk_6M);
      n++;
      if (n > TIMEOUT) abort_run("irq never rose");
    end
  endtask

  task automatic wait_air_bit(input int k);
    int n;
    n = 0;
    while (air_bits != k) begin
      @(negedge m_clk_6M);
      n++;
      if (n > TIMEOUT) abort_run("transmit bit never appeared on txbit");
    end
  endtask

  task automatic wait_tx_idle();
    bt_pkg::wb_data_t st;
    int n;
    n = 0;
    do begin
      wb_read(bt_pkg::REG_STATUS, st);
      n++;
      if (n > TIMEOUT) abort_run("transmitter stayed busy");
    end while (st[0]);
  endtask

  // x^7+x^4+1, register loads with its top bit set
  task automatic whiten_model(input bt_pkg::payload_t d, input bt_pkg::lfsr_t seed,
                              output bt_pkg::payload_t w);
    bt_pkg::lfsr_t l;
    logic fb;
    l = {1'b1, seed[5:0]};
    for (int i = 0; i < 32; i++) begin
      fb   = l[6];
      w[i] = d[i] ^ fb;
      l    = l << 1;
      l[0] = fb;
      l[4] = l[4] ^ fb;
    end
  endtask

  function automatic bt_pkg::chan_t hop_chan();
    return bt_pkg::chan_t'((int'(base) + pkt_count) % bt_pkg::NUM_CHANNELS);
  endfunction

  task automatic run_packet(input string name, input logic whiten, input bt_pkg::lfsr_t seed,
                            input bt_pkg::corr_t thresh, input int window,
                            input logic [95:0] mask, input logic expect_valid,
                            input logic arm, input logic sample_air);
    bt_pkg::payload_t data, exp_air, air, got;
    bt_pkg::wb_data_t st;
    data     = $urandom;
    err_mask = mask;
    wb_write(bt_pkg::REG_CONFIG, {9'd0, base, 1'b0, seed, 1'b0, thresh});
    exp_fk = hop_chan();
    wb_write(bt_pkg::REG_RX_WINDOW, window);
    wb_write(bt_pkg::REG_TX_DATA, data);
    if (arm) wb_write(bt_pkg::REG_CTRL, {29'd0, whiten, 2'b10});
    wb_write(bt_pkg::REG_CTRL, {29'd0, whiten, 2'b01});
    if (sample_air) begin
      for (int k = 0; k < 32; k++) begin
        wait_air_bit(65 + k);  // payload bit k follows 64 sync bits
        air[k] = txbit;
      end
      whiten_model(data, seed, exp_air);
      check_payload({name, " air"}, exp_air, air);
    end
    if (arm) wait_irq();
    wait_tx_idle();
    pkt_count++;
    exp_fk = hop_chan();
    wb_read(bt_pkg::REG_STATUS, st);
    check_chan({name, " fk"}, exp_fk, st[14:8]);
    if (arm) begin
      check_status({name, " status"}, {!expect_valid, expect_valid, 2'b00}, st[3:0]);
      if (expect_valid) begin
        wb_read(bt_pkg::REG_RX_DATA, got);
        check_payload({name, " rx data"}, data, got);
      end
    end
  endtask

  task automatic test_registers();
    bt_pkg::wb_data_t rd;
    wb_read(bt_pkg::REG_STATUS, rd);
    check_word("reset status", 32'd0, rd);
    wb_write(bt_pkg::REG_SYNC_LO, sync[31:0]);
    wb_write(bt_pkg::REG_SYNC_HI, sync[63:32]);
    wb_write(bt_pkg::REG_CONFIG, 32'h0000_3540);
    wb_write(bt_pkg::REG_RX_WINDOW, 32'd1234);
    wb_read(bt_pkg::REG_SYNC_LO, rd);
    check_word("sync lo", sync[31:0], rd);
    wb_read(bt_pkg::REG_SYNC_HI, rd);
    check_word("sync hi", sync[63:32], rd);
    wb_read(bt_pkg::REG_CONFIG, rd);
    check_word("config", 32'h0000_3540, rd);
    wb_read(bt_pkg::REG_RX_WINDOW, rd);
    check_word("rx window", 32'd1234, rd);
  endtask

  task automatic test_hop_counter();
    base = bt_pkg::chan_t'((76 - (pkt_count % bt_pkg::NUM_CHANNELS) + 79) % 79);
    for (int i = 0; i < 6; i++)  // 76 up through the wrap to 3
      run_packet("hop", 1'b0, 7'd0, 7'd64, 1000, 96'd0, 1'b0, 1'b0, 1'b0);
    check_chan("hop wrap", 7'd3, fk);
  endtask

  initial begin
    void'($urandom(32'h523d));
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_wdata = '0;
    rxbit = 1'b0;
    err_mask = '0;
    base = '0;
    exp_fk = '0;
    pkt_count = 0;
    reset = 1'b1;
    sync = {$urandom, $urandom};
    repeat (4) @(posedge m_clk_6M);
    reset <= 1'b0;
    test_registers();
    run_packet("plain loopback", 1'b0, 7'd0, 7'd64, 1000, 96'd0, 1'b1, 1'b1, 1'b0);
    run_packet("whitening", 1'b1, bt_pkg::lfsr_t'($urandom), 7'd64, 1000, 96'd0,
               1'b1, 1'b1, 1'b1);
    run_packet("four errors", 1'b1, bt_pkg::lfsr_t'($urandom), 7'd60, 1000,
               (96'd1 << 3) | (96'd1 << 17) | (96'd1 << 40) | (96'd1 << 61),
               1'b1, 1'b1, 1'b0);
    run_packet("five errors", 1'b0, 7'd0, 7'd60, 120,
               (96'd1 << 3) | (96'd1 << 17) | (96'd1 << 40) | (96'd1 << 50) | (96'd1 << 61),
               1'b0, 1'b1, 1'b0);
    test_hop_counter();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule
